/* bender.yml */
package:
  name: switch_ingress

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/switch_pkg.sv
      - hdl/pkt_buffer.sv
      - hdl/desc_fifo.sv
      - hdl/word_counter.sv
      - hdl/ingress_ctrl.sv
      - hdl/egress_ctrl.sv
      - hdl/switch_ingress.sv
      - target: test
        files:
          - testbench/tb_switch_ingress.sv

/* tb.f */
+incdir+hdl
hdl/switch_pkg.sv
hdl/pkt_buffer.sv
hdl/desc_fifo.sv
hdl/word_counter.sv
hdl/ingress_ctrl.sv
hdl/egress_ctrl.sv
hdl/switch_ingress.sv
testbench/tb_switch_ingress.sv

/* testbench/tb_switch_ingress.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module tb_switch_ingress;

    localparam int DRAIN_LIMIT = 3000;

    logic                      clk;
    logic                      rst;
    logic                      wr_sop;
    logic                      wr_eop;
    logic                      wr_vld;
    logic [`SWITCH_DATA_W-1:0] wr_data;
    logic                      xfer_stop;
    logic                      new_packet;
    logic [3:0]                dest_port;
    logic [2:0]                prior;
    logic [`SWITCH_LEN_W-1:0]  length;
    logic                      data_vld;
    logic [`SWITCH_DATA_W-1:0] data;
    logic                      drop;
    logic                      stop_seen;

    integer seed = 32'hf74e;
    int     stall_mode;
    int     val_errors;
    int     other_errors;
    int     exp_drops;
    int     drop_seen;
    int     words_left;
    int     model_free;
    int     model_queued;
    logic [15:0]               exp_hdr [$];
    logic [`SWITCH_DATA_W-1:0] exp_data [$];

    switch_ingress switch_ingress_i (
        .clk(clk), .rst(rst),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .xfer_stop(xfer_stop),
        .new_packet(new_packet), .dest_port(dest_port), .prior(prior), .length(length),
        .data_vld(data_vld), .data(data), .drop(drop)
    );

    always #2 clk = ~clk;

    // accept (1) or drop (0) for one packet
    function automatic bit pkt_outcome(input logic [15:0] hdr, input int sent,
                                       input int free, input int queued);
        int len;
        len = hdr[15:7];
        if (len == 0 || len > `SWITCH_MAX_PKT_WORDS) begin
            return 1'b0;
        end
        if (len > free || queued >= `SWITCH_DESC_DEPTH) begin
            return 1'b0;
        end
        return sent == len;
    endfunction

    task automatic print_counts;
        $display("value errors: %0d, other errors: %0d, drops seen %0d of %0d",
                 val_errors, other_errors, drop_seen, exp_drops);
    endtask

    task automatic drive_word(input bit sop, input bit eop, input logic [15:0] word);
        @(negedge clk);
        wr_vld  = 1'b1;
        wr_sop  = sop;
        wr_eop  = eop;
        wr_data = word;
    endtask

    task automatic bus_idle;
        @(negedge clk);
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
    endtask

    // without eop the packet is cut off by the next header
    task automatic send_pkt(input logic [3:0] dst, input logic [2:0] pri,
                            input logic [8:0] len, input int n_words, input bit with_eop);
        logic [15:0]               hdr;
        logic [`SWITCH_DATA_W-1:0] word;
        bit                        ok;
        hdr = {len, pri, dst};
        ok  = pkt_outcome(hdr, with_eop ? n_words : 0, model_free, model_queued);
        if (ok) begin
            exp_hdr.push_back(hdr);
            model_free   -= len;
            model_queued += 1;
        end else begin
            exp_drops++;
        end
        drive_word(1'b1, 1'b0, hdr);
        for (int i = 0; i < n_words; i++) begin
            word = $random(seed);
            if (ok) begin
                exp_data.push_back(word);
            end
            drive_word(1'b0, with_eop && (i == n_words - 1), word);
        end
    endtask

    // everything sent has come out, so the DUT is empty again
    task automatic wait_drain;
        int cycles;
        cycles = 0;
        while (exp_hdr.size() != 0 || exp_data.size() != 0 || words_left != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("timeout: %0d packets never came out by time %0t",
                         exp_hdr.size(), $time);
                other_errors++;
                print_counts();
                $display("RESULT: FAIL");
                $finish;
            end
        end
        model_free   = `SWITCH_BUF_WORDS;
        model_queued = 0;
    endtask

    always @(negedge clk) begin
        case (stall_mode)
            1:       xfer_stop = 1'b1;
            2:       xfer_stop = ($random(seed) & 3) < 2;
            default: xfer_stop = 1'b0;
        endcase
    end

    // xfer_stop as the DUT saw it on the last rising edge
    always @(posedge clk) begin
        stop_seen <= xfer_stop;
    end

    always @(negedge clk) begin : check_outputs
        logic [15:0] hdr;
        if (!rst) begin
            if ((new_packet || data_vld) && stop_seen) begin
                $display("error: output moved while xfer_stop was high at time %0t", $time);
                other_errors++;
            end
            if (new_packet) begin
                if (exp_hdr.size() == 0 || words_left != 0) begin
                    $display("error: new_packet with no packet due at time %0t", $time);
                    other_errors++;
                end else begin
                    hdr = exp_hdr.pop_front();
                    if (dest_port !== hdr[3:0] || prior !== hdr[6:4] || length !== hdr[15:7]) begin
                        $display("[FAIL] %0t: header %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
                                 dest_port, prior, length, hdr[3:0], hdr[6:4], hdr[15:7]);
                        val_errors++;
                    end
                    words_left = hdr[15:7];
                end
            end
            if (data_vld) begin
                if (words_left == 0 || exp_data.size() == 0) begin
                    $display("error: extra payload word at time %0t", $time);
                    other_errors++;
                end else begin
                    if (data !== exp_data[0]) begin
                        $display("[FAIL] %0t: data %h, expected %h", $time, data, exp_data[0]);
                        val_errors++;
                    end
                    void'(exp_data.pop_front());
                    words_left--;
                end
            end
            if (drop) begin
                drop_seen++;
            end
        end
    end

    initial begin : main_flow
        int len;
        clk = 1'b0;
        rst = 1'b1;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        wr_vld = 1'b0;
        wr_data = '0;
        xfer_stop = 1'b0;
        stall_mode = 0;
        model_free = `SWITCH_BUF_WORDS;
        model_queued = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // one legal packet
        send_pkt(4'h3, 3'd5, 9'd6, 6, 1'b1);
        bus_idle();
        wait_drain();

        // back to back, with long, cut off and short packets in between
        send_pkt(4'h1, 3'd2, 9'd4, 4, 1'b1);
        send_pkt(4'h2, 3'd0, 9'd0, 0, 1'b1);
        send_pkt(4'h7, 3'd7, 9'd3, 5, 1'b1);
        send_pkt(4'h9, 3'd1, 9'd10, 10, 1'b1);
        send_pkt(4'h4, 3'd3, 9'd5, 2, 1'b0);
        send_pkt(4'h5, 3'd6, 9'd8, 8, 1'b1);
        send_pkt(4'h6, 3'd1, 9'd7, 4, 1'b1);
        send_pkt(4'h0, 3'd4, 9'd1, 1, 1'b1);
        bus_idle();
        wait_drain();

        // illegal lengths
        send_pkt(4'h2, 3'd2, 9'd0, 0, 1'b1);
        send_pkt(4'h3, 3'd3, 9'd33, 33, 1'b1);
        send_pkt(4'h1, 3'd1, 9'd300, 2, 1'b1);
        send_pkt(4'h8, 3'd2, 9'd12, 12, 1'b1);
        bus_idle();
        wait_drain();

        // egress held off, buffer and queue overflow
        stall_mode = 1;
        for (int p = 0; p < 7; p++) begin
            len = 12 + ($unsigned($random(seed)) % 13);
            send_pkt(4'(p), 3'(p), 9'(len), len, 1'b1);
        end
        bus_idle();
        stall_mode = 0;
        wait_drain();

        // random stalls while streaming
        stall_mode = 2;
        for (int p = 0; p < 4; p++) begin
            len = 1 + ($unsigned($random(seed)) % 16);
            send_pkt(4'(p + 10), 3'(p + 2), 9'(len), len, 1'b1);
        end
        bus_idle();
        wait_drain();
        stall_mode = 0;

        if (drop_seen != exp_drops) begin
            $display("[FAIL] %0t: %0d drop pulses, expected %0d", $time, drop_seen, exp_drops);
            val_errors++;
        end
        print_counts();
        if (val_errors == 0 && other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/switch_ingress.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module switch_ingress (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_sop,
    input  logic                      wr_eop,
    input  logic                      wr_vld,
    input  logic [`SWITCH_DATA_W-1:0] wr_data,
    input  logic                      xfer_stop,
    output logic                      new_packet,
    output logic [3:0]                dest_port,
    output logic [2:0]                prior,
    output logic [`SWITCH_LEN_W-1:0]  length,
    output logic                      data_vld,
    output logic [`SWITCH_DATA_W-1:0] data,
    output logic                      drop
);

    logic                      buf_wr_en;
    logic                      buf_commit;
    logic                      buf_rollback;
    logic [`SWITCH_BUF_AW:0]   free_words;
    logic                      rd_en;
    logic [`SWITCH_DATA_W-1:0] rd_data;
    logic                      push;
    logic                      pop;
    switch_pkg::desc_t         push_desc;
    switch_pkg::desc_t         head_desc;
    logic                      fifo_empty;
    logic                      fifo_full;
    logic                      in_load;
    logic [`SWITCH_LEN_W-1:0]  in_load_value;
    logic                      in_dec;
    logic                      in_zero;
    logic                      out_load;
    logic [`SWITCH_LEN_W-1:0]  out_load_value;
    logic                      out_dec;
    logic                      out_zero;

    ingress_ctrl ingress_ctrl_i (
        .clk(clk), .rst(rst),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .free_words(free_words), .fifo_full(fifo_full), .cnt_zero(in_zero),
        .buf_wr_en(buf_wr_en), .buf_commit(buf_commit), .buf_rollback(buf_rollback),
        .cnt_load(in_load), .cnt_load_value(in_load_value), .cnt_dec(in_dec),
        .push(push), .push_desc(push_desc), .drop(drop)
    );

    // counts payload words of the packet being received
    word_counter in_cnt (
        .clk(clk), .rst(rst),
        .load(in_load), .load_value(in_load_value), .dec(in_dec), .zero(in_zero)
    );

    pkt_buffer pkt_buffer_i (
        .clk(clk), .rst(rst),
        .wr_en(buf_wr_en), .wr_data(wr_data),
        .commit(buf_commit), .rollback(buf_rollback),
        .rd_en(rd_en), .rd_data(rd_data), .free_words(free_words)
    );

    desc_fifo desc_fifo_i (
        .clk(clk), .rst(rst),
        .push(push), .push_desc(push_desc), .pop(pop),
        .head_desc(head_desc), .empty(fifo_empty), .full(fifo_full)
    );

    // counts reads still to issue for the packet on the way out
    word_counter out_cnt (
        .clk(clk), .rst(rst),
        .load(out_load), .load_value(out_load_value), .dec(out_dec), .zero(out_zero)
    );

    egress_ctrl egress_ctrl_i (
        .clk(clk), .rst(rst),
        .fifo_empty(fifo_empty), .head_desc(head_desc), .cnt_zero(out_zero),
        .xfer_stop(xfer_stop), .rd_data(rd_data),
        .pop(pop), .rd_en(rd_en),
        .cnt_load(out_load), .cnt_load_value(out_load_value), .cnt_dec(out_dec),
        .new_packet(new_packet), .dest_port(dest_port), .prior(prior), .length(length),
        .data_vld(data_vld), .data(data)
    );

endmodule

/* hdl/egress_ctrl.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module egress_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fifo_empty,
    input  switch_pkg::desc_t         head_desc,
    input  logic                      cnt_zero,
    input  logic                      xfer_stop,
    input  logic [`SWITCH_DATA_W-1:0] rd_data,
    output logic                      pop,
    output logic                      rd_en,
    output logic                      cnt_load,
    output logic [`SWITCH_LEN_W-1:0]  cnt_load_value,
    output logic                      cnt_dec,
    output logic                      new_packet,
    output logic [3:0]                dest_port,
    output logic [2:0]                prior,
    output logic [`SWITCH_LEN_W-1:0]  length,
    output logic                      data_vld,
    output logic [`SWITCH_DATA_W-1:0] data
);

    switch_pkg::egress_state_t state;

    // no new packet taken while the far side is stalling
    assign pop            = (state == switch_pkg::eg_idle) && !fifo_empty && !xfer_stop;
    assign cnt_load       = pop;
    assign cnt_load_value = head_desc.length;

    // one read per unstalled cycle until all words are issued
    assign rd_en   = (state == switch_pkg::eg_stream) && !xfer_stop && !cnt_zero;
    assign cnt_dec = rd_en;

    // buffer output is already registered, so data lines up with data_vld
    assign data = rd_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= switch_pkg::eg_idle;
            new_packet <= 1'b0;
            data_vld   <= 1'b0;
        end else begin
            new_packet <= pop;
            data_vld   <= rd_en;
            case (state)
                switch_pkg::eg_idle: begin
                    if (pop) begin
                        state <= switch_pkg::eg_announce;
                    end
                end
                switch_pkg::eg_announce: begin
                    if (!xfer_stop) begin
                        state <= switch_pkg::eg_stream;
                    end
                end
                switch_pkg::eg_stream: begin
                    if (cnt_zero) begin
                        state <= switch_pkg::eg_idle;
                    end
                end
                default: state <= switch_pkg::eg_idle;
            endcase
        end
    end

    // header fields held until the next announce
    always_ff @(posedge clk) begin
        if (pop) begin
            dest_port <= head_desc.dest_port;
            prior     <= head_desc.prior;
            length    <= head_desc.length;
        end
    end

endmodule

/* hdl/ingress_ctrl.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module ingress_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_sop,
    input  logic                      wr_eop,
    input  logic                      wr_vld,
    input  logic [`SWITCH_DATA_W-1:0] wr_data,
    input  logic [`SWITCH_BUF_AW:0]   free_words,
    input  logic                      fifo_full,
    input  logic                      cnt_zero,
    output logic                      buf_wr_en,
    output logic                      buf_commit,
    output logic                      buf_rollback,
    output logic                      cnt_load,
    output logic [`SWITCH_LEN_W-1:0]  cnt_load_value,
    output logic                      cnt_dec,
    output logic                      push,
    output switch_pkg::desc_t         push_desc,
    output logic                      drop
);

    switch_pkg::ingress_state_t state;
    switch_pkg::ingress_state_t state_next;
    switch_pkg::desc_t          hdr_in;
    logic                       hdr_ok;
    logic                       reject;

    assign hdr_in = switch_pkg::desc_t'(wr_data);
    assign hdr_ok = (hdr_in.length != '0) && (hdr_in.length <= `SWITCH_MAX_PKT_WORDS) &&
                    (hdr_in.length <= free_words) && !fifo_full;

    // counter holds the words still expected after the current one
    assign cnt_load_value = hdr_in.length - 1'b1;

    always_comb begin
        state_next   = state;
        buf_wr_en    = 1'b0;
        buf_commit   = 1'b0;
        buf_rollback = 1'b0;
        cnt_load     = 1'b0;
        cnt_dec      = 1'b0;
        push         = 1'b0;
        reject       = 1'b0;
        if (wr_vld && wr_sop) begin
            // sop inside a packet cuts it off
            if (state == switch_pkg::in_body) begin
                buf_rollback = 1'b1;
                reject       = 1'b1;
            end
            if (hdr_ok) begin
                cnt_load   = 1'b1;
                state_next = switch_pkg::in_body;
            end else begin
                reject     = 1'b1;
                state_next = switch_pkg::in_idle;
            end
        end else if (wr_vld && state == switch_pkg::in_body) begin
            if (cnt_zero && wr_eop) begin
                // exact length, last word goes in with the commit
                buf_wr_en  = 1'b1;
                buf_commit = 1'b1;
                push       = 1'b1;
                state_next = switch_pkg::in_idle;
            end else if (cnt_zero || wr_eop) begin
                // too long or too short
                buf_rollback = 1'b1;
                reject       = 1'b1;
                state_next   = switch_pkg::in_idle;
            end else begin
                buf_wr_en = 1'b1;
                cnt_dec   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= switch_pkg::in_idle;
            drop  <= 1'b0;
        end else begin
            state <= state_next;
            drop  <= reject;
        end
    end

    // header kept until the descriptor is pushed at eop
    always_ff @(posedge clk) begin
        if (cnt_load) begin
            push_desc <= hdr_in;
        end
    end

    // free space only grows between header and eop
    a_commit_fits: assert property (@(posedge clk) disable iff (rst)
        buf_commit |-> push_desc.length <= free_words)
        else $error("committed packet larger than free buffer space");

endmodule

/* hdl/word_counter.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module word_counter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  logic [`SWITCH_LEN_W-1:0] load_value,
    input  logic                     dec,
    output logic                     zero
);

    logic [`SWITCH_LEN_W-1:0] count;

    assign zero = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            // load wins over dec
            count <= load_value;
        end else if (dec) begin
            count <= count - 1'b1;
        end
    end

    a_no_dec_at_zero: assert property (@(posedge clk) disable iff (rst)
        (dec && !load) |-> !zero)
        else $error("word_counter decremented at zero");

endmodule

/* hdl/desc_fifo.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module desc_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  switch_pkg::desc_t  push_desc,
    input  logic               pop,
    output switch_pkg::desc_t  head_desc,
    output logic               empty,
    output logic               full
);

    localparam int AW = $clog2(`SWITCH_DESC_DEPTH);

    switch_pkg::desc_t entries [`SWITCH_DESC_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    // show-ahead, head entry visible without a pop
    assign head_desc = entries[rd_ptr[AW-1:0]];
    assign empty     = (wr_ptr == rd_ptr);
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr[AW-1:0]] <= push_desc;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("desc_fifo push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("desc_fifo pop while empty");

endmodule

/* hdl/pkt_buffer.sv */
`timescale 1ns/1ns
`include "switch_config.svh"

module pkt_buffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic [`SWITCH_DATA_W-1:0] wr_data,
    input  logic                      commit,
    input  logic                      rollback,
    input  logic                      rd_en,
    output logic [`SWITCH_DATA_W-1:0] rd_data,
    output logic [`SWITCH_BUF_AW:0]   free_words
);

    localparam int AW = `SWITCH_BUF_AW;

    logic [`SWITCH_DATA_W-1:0] mem [`SWITCH_BUF_WORDS];

    // one extra bit on each pointer tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] cmt_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] used_words;
    logic [AW:0] wr_ptr_next;

    assign wr_ptr_next = wr_en ? wr_ptr + 1'b1 : wr_ptr;

    // space freed by reads, tentative words not counted
    assign used_words = cmt_ptr - rd_ptr;
    assign free_words = (AW + 1)'(`SWITCH_BUF_WORDS) - used_words;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            cmt_ptr <= '0;
            rd_ptr  <= '0;
        end else begin
            if (rollback) begin
                wr_ptr <= cmt_ptr;
            end else begin
                wr_ptr <= wr_ptr_next;
            end
            // eop word may be written on the commit edge
            if (commit) begin
                cmt_ptr <= wr_ptr_next;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr[AW-1:0]];
        end
    end

    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (wr_ptr - rd_ptr) != (AW + 1)'(`SWITCH_BUF_WORDS))
        else $error("pkt_buffer write with no free space");

    // egress must never read a packet that is not committed yet
    a_no_read_past_commit: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> rd_ptr != cmt_ptr)
        else $error("pkt_buffer read past committed pointer");

endmodule

/* hdl/switch_pkg.sv */
`include "switch_config.svh"

package switch_pkg;

    // same bit layout as the header word
    // length 15:7, prior 6:4, dest_port 3:0
    typedef struct packed {
        logic [`SWITCH_LEN_W-1:0] length;
        logic [2:0]               prior;
        logic [3:0]               dest_port;
    } desc_t;

    typedef enum logic {
        in_idle,
        in_body
    } ingress_state_t;

    typedef enum logic [1:0] {
        eg_idle,
        eg_announce,
        eg_stream
    } egress_state_t;

endpackage

/* hdl/switch_config.svh */
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// payload word width
`define SWITCH_DATA_W 16

// circular payload buffer
`define SWITCH_BUF_WORDS 64
`define SWITCH_BUF_AW 6

// header length field and accepted packet size
`define SWITCH_LEN_W 9
`define SWITCH_MAX_PKT_WORDS 32

`define SWITCH_DESC_DEPTH 4

`endif
